// File: rtl/bus_decode.sv
`timescale 1ns/1ps

module bus_decode #(
    parameter int NUM_CHANNELS = 4
) (
    input  logic [soc_bus_pkg::ADDR_WIDTH-1:0] data_addr,
    input  logic                               ren,
    input  logic                               wen,
    input  logic                               sys_ready,
    output logic [NUM_CHANNELS-1:0]            wr_sel,
    output logic [NUM_CHANNELS-1:0]            rd_sel,
    output logic                               id_sel,
    // bit 0 flags an unmapped read, bit 1 an unmapped write
    output logic [1:0]                         unmapped
);

    localparam int IDX_W = soc_map_pkg::CH_INDEX_WIDTH;

    logic             rd_go;
    logic             wr_go;
    logic [IDX_W-1:0] ch_idx;
    logic             ch_hit;
    logic             is_id;

    // strobes count only once the block is out of reset
    assign rd_go = ren && sys_ready;
    assign wr_go = wen && sys_ready;

    // channel index is the upper address field
    assign ch_idx = data_addr[soc_bus_pkg::ADDR_WIDTH-1:soc_map_pkg::CH_STRIDE_SHIFT];

    // index inside the row of channels
    assign ch_hit = ch_idx < NUM_CHANNELS;

    assign is_id = data_addr == soc_map_pkg::ID_ADDR;

    // one-hot selects, at most one bit high
    always_comb begin
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            wr_sel[i] = wr_go && (ch_idx == IDX_W'(i));
            rd_sel[i] = rd_go && (ch_idx == IDX_W'(i));
        end
    end

    // ID word is read-only
    assign id_sel = rd_go && is_id;

    // the ID window is outside the channel range
    // so a write there falls into the unmapped case
    assign unmapped[0] = rd_go && !ch_hit && !is_id;
    assign unmapped[1] = wr_go && !ch_hit;

endmodule

// File: rtl/read_mux.sv
`timescale 1ns/1ps

module read_mux #(
    parameter int NUM_CHANNELS = 4
) (
    input  logic                                  clk,
    input  logic                                  sys_reset_n,
    input  logic [NUM_CHANNELS-1:0]               rd_sel,
    input  logic                                  id_sel,
    // bit 0 unmapped read, bit 1 unmapped write
    input  logic [1:0]                            unmapped,
    input  soc_bus_pkg::word_t [NUM_CHANNELS-1:0] ch_words,
    output soc_bus_pkg::word_t                    rd_data,
    output logic                                  rd_valid,
    output logic                                  bus_error
);

    soc_bus_pkg::word_t sel_word;
    logic               is_read;
    logic               any_access;

    // selects are one-hot, so a priority chain is enough
    always_comb begin
        sel_word = soc_bus_pkg::UNMAPPED_WORD;
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            if (rd_sel[i]) begin
                sel_word = ch_words[i];
            end
        end
        if (id_sel) begin
            sel_word = soc_map_pkg::ID_VALUE;
        end
    end

    // every read gets an answer, mapped or not
    assign is_read = (|rd_sel) || id_sel || unmapped[0];

    // accesses that reach this block, writes only when unmapped
    assign any_access = is_read || unmapped[1];

    always_ff @(posedge clk or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            rd_data   <= '0;
            rd_valid  <= 1'b0;
            bus_error <= 1'b0;
        end else begin
            // single-cycle pulses, one edge after the strobe
            rd_valid  <= is_read;
            bus_error <= |unmapped;
            // data is only meaningful while rd_valid is high
            if (any_access) begin
                rd_data <= sel_word;
            end
        end
    end

endmodule

// File: rtl/reset_sync.sv
`timescale 1ns/1ps

module reset_sync (
    input  logic clk,
    input  logic ext_reset,
    output logic sys_reset_n,
    output logic sys_ready
);

    // release counter, cleared at once by ext_reset
    logic [3:0] rst_cnt;

    always_ff @(posedge clk or negedge ext_reset) begin
        if (!ext_reset) begin
            rst_cnt <= '0;
        end else if (!sys_ready) begin
            // stops at all ones
            rst_cnt <= rst_cnt + 4'd1;
        end
    end

    // 15 edges after release the count saturates
    // last step is 1110 -> 1111, one bit, so no glitch on the AND
    assign sys_ready = &rst_cnt;

    // assert is async through rst_cnt, release lands on a clk edge
    assign sys_reset_n = sys_ready;

endmodule

// File: rtl/soc_bus_pkg.sv
package soc_bus_pkg;

    // data path of the CPU load/store port
    typedef logic [31:0] word_t;

    // one strobe bit per byte of word_t
    localparam int BYTE_LANES = 4;

    // low address bits seen by the timer block
    // upper CPU address bits are decoded outside this block
    localparam int ADDR_WIDTH = 8;

    // returned on a read that hits no register
    localparam word_t UNMAPPED_WORD = '0;

endpackage

// File: rtl/soc_map_pkg.sv
package soc_map_pkg;

    // channel i occupies a 16-byte window at i << CH_STRIDE_SHIFT
    localparam int CH_STRIDE_SHIFT = 4;

    // upper address field picks the channel
    localparam int CH_INDEX_WIDTH = soc_bus_pkg::ADDR_WIDTH - CH_STRIDE_SHIFT;

    // register offsets inside one channel window
    localparam logic [CH_STRIDE_SHIFT-1:0] REG_CTRL = 4'h0;
    localparam logic [CH_STRIDE_SHIFT-1:0] REG_DIV = 4'h4;
    localparam logic [CH_STRIDE_SHIFT-1:0] REG_CMP = 4'h8;
    localparam logic [CH_STRIDE_SHIFT-1:0] REG_COUNT = 4'hC;

    // read-only ID word, sits in the window of index 15
    // which is never a channel
    localparam logic [soc_bus_pkg::ADDR_WIDTH-1:0] ID_ADDR = 8'hF0;

    // ascii "TMR" plus revision byte
    localparam soc_bus_pkg::word_t ID_VALUE = 32'h544D_5201;

    // CTRL fields, both in byte lane 0
    // en is kept, irq-clear is a write-only action
    // reading bit 1 returns the pending irq
    localparam int CTRL_EN_BIT = 0;
    localparam int CTRL_IRQ_CLR_BIT = 1;

endpackage

// File: rtl/timer_channel.sv
`timescale 1ns/1ps

module timer_channel #(
    parameter int COUNT_WIDTH = 32
) (
    input  logic                                    clk,
    input  logic                                    sys_reset_n,
    input  logic                                    wr_sel,
    input  logic [soc_map_pkg::CH_STRIDE_SHIFT-1:0] reg_ofs,
    input  soc_bus_pkg::word_t                      wr_data,
    input  logic [soc_bus_pkg::BYTE_LANES-1:0]      byte_sel,
    output soc_bus_pkg::word_t                      ch_rd_word,
    output logic                                    irq
);

    logic                   ctrl_en;
    logic [COUNT_WIDTH-1:0] div_q;
    logic [COUNT_WIDTH-1:0] presc_q;
    logic [COUNT_WIDTH-1:0] count_q;
    logic [COUNT_WIDTH-1:0] count_d;
    soc_bus_pkg::word_t     cmp_q;
    logic                   wr_ctrl;
    logic                   wr_div;
    logic                   wr_cmp;
    logic                   wr_count;
    logic                   tick;
    logic                   irq_set;
    logic                   irq_clr;

    // replace only the byte lanes that are set
    function automatic soc_bus_pkg::word_t merge_lanes(
        input soc_bus_pkg::word_t                 old_word,
        input soc_bus_pkg::word_t                 new_word,
        input logic [soc_bus_pkg::BYTE_LANES-1:0] lanes
    );
        soc_bus_pkg::word_t result;
        result = old_word;
        for (int b = 0; b < soc_bus_pkg::BYTE_LANES; b++) begin
            if (lanes[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    // CTRL fields live in lane 0 only
    assign wr_ctrl = wr_sel && (reg_ofs == soc_map_pkg::REG_CTRL) && byte_sel[0];
    assign wr_div = wr_sel && (reg_ofs == soc_map_pkg::REG_DIV);
    assign wr_cmp = wr_sel && (reg_ofs == soc_map_pkg::REG_CMP);
    assign wr_count = wr_sel && (reg_ofs == soc_map_pkg::REG_COUNT);

    // prescaler wrap, one count step
    assign tick = ctrl_en && (presc_q == div_q);

    // next count, a bus load wins over a tick
    always_comb begin
        count_d = count_q;
        if (wr_count) begin
            count_d = COUNT_WIDTH'(merge_lanes(soc_bus_pkg::word_t'(count_q), wr_data,
                                               byte_sel));
        end else if (tick) begin
            count_d = count_q + 1'b1;
        end
    end

    // irq fires only on the step into CMP, not while sitting there
    assign irq_set = (count_d != count_q) && (soc_bus_pkg::word_t'(count_d) == cmp_q);
    assign irq_clr = wr_ctrl && wr_data[soc_map_pkg::CTRL_IRQ_CLR_BIT];

    always_ff @(posedge clk or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            ctrl_en <= 1'b0;
            div_q   <= '0;
            cmp_q   <= '0;
            presc_q <= '0;
            count_q <= '0;
            irq     <= 1'b0;
        end else begin
            if (wr_ctrl) begin
                ctrl_en <= wr_data[soc_map_pkg::CTRL_EN_BIT];
            end
            if (wr_div) begin
                div_q <= COUNT_WIDTH'(merge_lanes(soc_bus_pkg::word_t'(div_q), wr_data,
                                                  byte_sel));
            end
            if (wr_cmp) begin
                cmp_q <= merge_lanes(cmp_q, wr_data, byte_sel);
            end
            // enabling restarts the prescaler, count is kept
            if (wr_ctrl && wr_data[soc_map_pkg::CTRL_EN_BIT]) begin
                presc_q <= '0;
            end else if (tick) begin
                presc_q <= '0;
            end else if (ctrl_en) begin
                presc_q <= presc_q + 1'b1;
            end
            count_q <= count_d;
            // a new match in the same cycle beats the clear
            if (irq_set) begin
                irq <= 1'b1;
            end else if (irq_clr) begin
                irq <= 1'b0;
            end
        end
    end

    // read-back of the addressed register, narrow ones zero-extended
    always_comb begin
        ch_rd_word = soc_bus_pkg::UNMAPPED_WORD;
        case (reg_ofs)
            soc_map_pkg::REG_CTRL: begin
                ch_rd_word[soc_map_pkg::CTRL_EN_BIT] = ctrl_en;
                ch_rd_word[soc_map_pkg::CTRL_IRQ_CLR_BIT] = irq;
            end
            soc_map_pkg::REG_DIV: ch_rd_word = soc_bus_pkg::word_t'(div_q);
            soc_map_pkg::REG_CMP: ch_rd_word = cmp_q;
            soc_map_pkg::REG_COUNT: ch_rd_word = soc_bus_pkg::word_t'(count_q);
            default: ch_rd_word = soc_bus_pkg::UNMAPPED_WORD;
        endcase
    end

endmodule

// File: rtl/timer_subsystem.sv
`timescale 1ns/1ps

module timer_subsystem #(
    parameter int NUM_CHANNELS = 4,
    parameter int COUNT_WIDTH = 32
) (
    input  logic                               clk,
    input  logic                               ext_reset,
    input  logic [soc_bus_pkg::ADDR_WIDTH-1:0] data_addr,
    input  logic                               ren,
    input  logic                               wen,
    input  soc_bus_pkg::word_t                 wr_data,
    input  logic [soc_bus_pkg::BYTE_LANES-1:0] byte_sel,
    output soc_bus_pkg::word_t                 rd_data,
    output logic                               rd_valid,
    output logic                               bus_error,
    output logic [NUM_CHANNELS-1:0]            irq,
    output logic                               sys_ready
);

    logic                                  sys_reset_n;
    logic [NUM_CHANNELS-1:0]               wr_sel;
    logic [NUM_CHANNELS-1:0]               rd_sel;
    logic                                  id_sel;
    logic [1:0]                            unmapped;
    soc_bus_pkg::word_t [NUM_CHANNELS-1:0] ch_words;

    // internal reset and the ready level for the bus
    reset_sync reset_sync_i (
        .clk         (clk),
        .ext_reset   (ext_reset),
        .sys_reset_n (sys_reset_n),
        .sys_ready   (sys_ready)
    );

    // address decode, strobes already gated by sys_ready
    bus_decode #(
        .NUM_CHANNELS (NUM_CHANNELS)
    ) bus_decode_i (
        .data_addr (data_addr),
        .ren       (ren),
        .wen       (wen),
        .sys_ready (sys_ready),
        .wr_sel    (wr_sel),
        .rd_sel    (rd_sel),
        .id_sel    (id_sel),
        .unmapped  (unmapped)
    );

    // row of channels, all share the register offset field
    for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_channel
        timer_channel #(
            .COUNT_WIDTH (COUNT_WIDTH)
        ) timer_channel_i (
            .clk         (clk),
            .sys_reset_n (sys_reset_n),
            .wr_sel      (wr_sel[i]),
            .reg_ofs     (data_addr[soc_map_pkg::CH_STRIDE_SHIFT-1:0]),
            .wr_data     (wr_data),
            .byte_sel    (byte_sel),
            .ch_rd_word  (ch_words[i]),
            .irq         (irq[i])
        );
    end

    // registered read-back, one cycle latency
    read_mux #(
        .NUM_CHANNELS (NUM_CHANNELS)
    ) read_mux_i (
        .clk         (clk),
        .sys_reset_n (sys_reset_n),
        .rd_sel      (rd_sel),
        .id_sel      (id_sel),
        .unmapped    (unmapped),
        .ch_words    (ch_words),
        .rd_data     (rd_data),
        .rd_valid    (rd_valid),
        .bus_error   (bus_error)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the timer subsystem testbench under Verilator
# paths are relative to the project root, so start from there

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module tb_timer_subsystem \
    -f timer_subsystem.f -o tb_timer_subsystem
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/tb_timer_subsystem > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi

exit 0

// File: tb/tb_timer_subsystem.sv
`timescale 1ns/1ps

module tb_timer_subsystem;

    localparam int CLK_HALF = 10;
    localparam int RESET_CYCLES = 8;
    localparam int READY_LIMIT = 20;
    // watchdog budget per stim line
    localparam int CYCLES_PER_LINE = 20;
    localparam string STIM_PATH = "tb/timer_subsystem_stim.txt";

    logic        clk;
    logic        ext_reset;
    logic [7:0]  data_addr;
    logic        ren;
    logic        wen;
    logic [31:0] wr_data;
    logic [3:0]  byte_sel;
    logic [31:0] rd_data;
    logic        rd_valid;
    logic        bus_error;
    logic [3:0]  irq;
    logic        sys_ready;

    // per-test and run-wide bookkeeping
    int test_errs = 0;
    int total_errs = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int wd_cycles = 0;

    timer_subsystem dut_i (
        .clk       (clk),
        .ext_reset (ext_reset),
        .data_addr (data_addr),
        .ren       (ren),
        .wen       (wen),
        .wr_data   (wr_data),
        .byte_sel  (byte_sel),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid),
        .bus_error (bus_error),
        .irq       (irq),
        .sys_ready (sys_ready)
    );

    // 20 ns clock
    always #CLK_HALF clk = ~clk;

    // watchdog, armed once the stim file has been sized
    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk);
        $display("timeout: stimulus still running after %0d cycles", wd_cycles);
        $display("TEST FAILED");
        $finish;
    end

    task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("ERR %0t %s expected %h got %h", $time, sig, exp, got);
        test_errs++;
        total_errs++;
    endtask

    task automatic report_problem(input string msg);
        $display("%0t %s", $time, msg);
        test_errs++;
        total_errs++;
    endtask

    // count ops and idle cycles to size the watchdog
    task automatic scan_stim();
        int fd;
        int code;
        int n;
        int lines;
        int idle_total;
        logic [8*8-1:0]   op;
        logic [8*128-1:0] rest;
        lines = 0;
        idle_total = 0;
        fd = $fopen(STIM_PATH, "r");
        if (fd != 0) begin
            while ($fscanf(fd, "%s", op) == 1) begin
                if (op == "I") begin
                    code = $fscanf(fd, "%d", n);
                    if (code == 1) begin
                        idle_total += n;
                    end
                end
                if (op != "#") begin
                    lines++;
                end
                // rest of the line, comment text included
                code = $fgets(rest, fd);
            end
            $fclose(fd);
        end
        wd_cycles = CYCLES_PER_LINE * lines + idle_total + RESET_CYCLES + READY_LIMIT + 10;
    endtask

    // reset phase, then a read strobe held before ready
    task automatic check_reset();
        int waited;
        waited = 0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            if (rd_valid !== 1'b0) begin
                report_mismatch("rd_valid", 32'd0, {31'b0, rd_valid});
            end
            if (bus_error !== 1'b0) begin
                report_mismatch("bus_error", 32'd0, {31'b0, bus_error});
            end
            if (irq !== 4'b0) begin
                report_mismatch("irq", 32'd0, {28'b0, irq});
            end
            if (sys_ready !== 1'b0) begin
                report_mismatch("sys_ready", 32'd0, {31'b0, sys_ready});
            end
        end
        // release on the last reset negedge
        ext_reset = 1'b1;
        // strobe must be ignored until sys_ready
        data_addr = 8'hF0;
        ren = 1'b1;
        while (sys_ready !== 1'b1 && waited < READY_LIMIT) begin
            @(negedge clk);
            waited++;
            if (rd_valid !== 1'b0) begin
                report_mismatch("rd_valid", 32'd0, {31'b0, rd_valid});
            end
            if (bus_error !== 1'b0) begin
                report_mismatch("bus_error", 32'd0, {31'b0, bus_error});
            end
        end
        ren = 1'b0;
        if (sys_ready !== 1'b1) begin
            report_problem("sys_ready did not rise within 20 cycles of reset release");
        end
    endtask

    task automatic bus_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic [3:0] lanes, input logic exp_err);
        @(negedge clk);
        data_addr = addr;
        wr_data = data;
        byte_sel = lanes;
        wen = 1'b1;
        @(negedge clk);
        wen = 1'b0;
        // unmapped write flags one cycle after the strobe
        if (bus_error !== exp_err) begin
            report_mismatch("bus_error", {31'b0, exp_err}, {31'b0, bus_error});
        end
        if (rd_valid !== 1'b0) begin
            report_mismatch("rd_valid", 32'd0, {31'b0, rd_valid});
        end
    endtask

    task automatic bus_read(input logic [7:0] addr, input logic [31:0] exp_data,
                            input logic exp_err);
        @(negedge clk);
        data_addr = addr;
        ren = 1'b1;
        @(negedge clk);
        ren = 1'b0;
        // answer holds for the cycle after the capture edge
        if (rd_valid !== 1'b1) begin
            report_mismatch("rd_valid", 32'd1, {31'b0, rd_valid});
        end
        if (rd_data !== exp_data) begin
            report_mismatch("rd_data", exp_data, rd_data);
        end
        if (bus_error !== exp_err) begin
            report_mismatch("bus_error", {31'b0, exp_err}, {31'b0, bus_error});
        end
    endtask

    task automatic finish_test(input logic [8*24-1:0] name);
        if (test_errs == 0) begin
            tests_passed++;
            $display("test %0s: ok", name);
        end else begin
            tests_failed++;
            $display("test %0s: %0d errors", name, test_errs);
        end
        test_errs = 0;
    endtask

    initial begin
        int fd;
        int code;
        int idle_n;
        bit done;
        logic [8*8-1:0]   op;
        logic [8*24-1:0]  name;
        logic [8*128-1:0] rest;
        logic [7:0]       addr;
        logic [31:0]      value;
        logic [3:0]       lanes;
        logic             flag;
        clk = 1'b0;
        ext_reset = 1'b0;
        data_addr = 8'h00;
        ren = 1'b0;
        wen = 1'b0;
        wr_data = 32'h0;
        byte_sel = 4'h0;
        done = 1'b0;
        scan_stim();
        check_reset();
        fd = $fopen(STIM_PATH, "r");
        if (fd == 0) begin
            report_problem("could not open the stim file tb/timer_subsystem_stim.txt");
        end else begin
            while (!done) begin
                code = $fscanf(fd, "%s", op);
                if (code != 1) begin
                    done = 1'b1;
                end else if (op == "#") begin
                    code = $fgets(rest, fd);
                end else if (op == "W") begin
                    code = $fscanf(fd, "%h %h %h %h", addr, value, lanes, flag);
                    bus_write(addr, value, lanes, flag);
                end else if (op == "R") begin
                    code = $fscanf(fd, "%h %h %h", addr, value, flag);
                    bus_read(addr, value, flag);
                end else if (op == "I") begin
                    code = $fscanf(fd, "%d", idle_n);
                    repeat (idle_n) @(negedge clk);
                end else if (op == "Q") begin
                    code = $fscanf(fd, "%h", value);
                    if ({28'b0, irq} !== value) begin
                        report_mismatch("irq", value, {28'b0, irq});
                    end
                end else if (op == "T") begin
                    code = $fscanf(fd, "%s", name);
                    finish_test(name);
                end else begin
                    report_problem("stim file holds an unknown opcode");
                    done = 1'b1;
                end
            end
            $fclose(fd);
        end
        $display("summary: %0d ok, %0d with errors, %0d errors in all",
                 tests_passed, tests_failed, total_errs);
        if (total_errs == 0 && tests_passed > 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: tb/timer_subsystem_stim.txt
# W addr data lanes err | R addr data err | I cycles (decimal) | Q irq | T name
# hex fields, err is the expected bus_error, lanes is byte_sel
R F0 544D5201 0
T reset
W 04 12345678 F 0
R 04 12345678 0
W 08 A5A50000 F 0
R 08 A5A50000 0
W 34 0000BEEF F 0
R 34 0000BEEF 0
W 38 C3C3C3C3 F 0
R 38 C3C3C3C3 0
W 04 AABBCCDD 5 0
R 04 12BB56DD 0
T regs_lanes
# enable, 21 idle, disable gives 23 enabled edges, 23 / 4 = 5
W 14 00000003 F 0
W 10 00000001 1 0
I 21
W 10 00000000 1 0
R 1C 00000005 0
T counting
# DIV 4 so COUNT reaches CMP 2 after 10 enabled edges
W 28 00000002 F 0
W 24 00000004 F 0
W 20 00000001 1 0
Q 0
I 5
Q 0
I 6
Q 4
I 10
Q 4
W 20 00000002 1 0
Q 0
R 20 00000000 0
T compare_irq
# both channels run 34 enabled edges, 34 / 2 = 17 and 34 / 3 = 11
W 04 00000001 F 0
W 34 00000002 F 0
W 00 00000001 1 0
W 30 00000001 1 0
I 30
W 00 00000000 1 0
W 30 00000000 1 0
R 0C 00000011 0
W 0C 00000100 F 0
R 0C 00000100 0
R 3C 0000000B 0
Q 0
T independence
R 50 00000000 1
R E4 00000000 1
W 70 12345678 F 1
W F0 DEADBEEF F 1
R F0 544D5201 0
T unmapped

// File: timer_subsystem.f
rtl/soc_bus_pkg.sv
rtl/soc_map_pkg.sv
rtl/reset_sync.sv
rtl/bus_decode.sv
rtl/timer_channel.sv
rtl/read_mux.sv
rtl/timer_subsystem.sv
tb/tb_timer_subsystem.sv
